// File: common/rv_pkg.sv
package rv_pkg;

  // datapath width and register file shape, RV32E has 16 registers
  localparam int XLEN   = 32;
  localparam int NREG   = 16;
  localparam int REG_AW = 4;

  // micro-op buffer entries
  // decode starts out with this many credits
  localparam int FIFO_DEPTH = 4;
  // wide enough to hold FIFO_DEPTH itself
  localparam int CRED_W     = 3;

  // major opcodes kept in this slice
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_REG   = 7'b0110011;

  // alu codes are {funct7[5], funct3}
  localparam logic [3:0] ALU_ADD  = 4'b0000;
  localparam logic [3:0] ALU_SUB  = 4'b1000;
  localparam logic [3:0] ALU_SLL  = 4'b0001;
  localparam logic [3:0] ALU_SLT  = 4'b0010;
  localparam logic [3:0] ALU_SLTU = 4'b0011;
  localparam logic [3:0] ALU_XOR  = 4'b0100;
  localparam logic [3:0] ALU_SRL  = 4'b0101;
  localparam logic [3:0] ALU_SRA  = 4'b1101;
  localparam logic [3:0] ALU_OR   = 4'b0110;
  localparam logic [3:0] ALU_AND  = 4'b0111;

  // one instruction word seen in the three formats this slice decodes
  typedef union packed {
    // register-register
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    // 12-bit immediate, also carries shamt and the sra flag
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    // upper immediate for lui and auipc
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } inst_u;

endpackage

// File: common/uop_if.sv
`timescale 1ns/10ps

interface uop_if import rv_pkg::*; ();

  // push side, decode into the buffer
  logic              push;
  logic [3:0]        push_alu_op;
  logic [XLEN-1:0]   push_op1;
  logic [XLEN-1:0]   push_op2;
  logic [REG_AW-1:0] push_rd;
  logic              push_wen;
  // one credit back to decode per pop
  logic              credit;

  // pop side, buffer into execute
  logic              pop_valid;
  logic              pop;
  logic [3:0]        pop_alu_op;
  logic [XLEN-1:0]   pop_op1;
  logic [XLEN-1:0]   pop_op2;
  logic [REG_AW-1:0] pop_rd;
  logic              pop_wen;

  modport prod (output push, push_alu_op, push_op1, push_op2, push_rd, push_wen, input credit);
  modport buf_in (input push, push_alu_op, push_op1, push_op2, push_rd, push_wen, output credit);
  modport buf_out (output pop_valid, pop_alu_op, pop_op1, pop_op2, pop_rd, pop_wen, input pop);
  modport cons (input pop_valid, pop_alu_op, pop_op1, pop_op2, pop_rd, pop_wen, output pop);

endinterface

// File: hw/decode/idu_decoder.sv
`timescale 1ns/10ps

module idu_decoder import rv_pkg::*; (
  input  inst_u             inst_i,
  input  logic [XLEN-1:0]   pc_i,
  input  logic [XLEN-1:0]   rdata1_i,
  input  logic [XLEN-1:0]   rdata2_i,
  output logic [XLEN-1:0]   op1_o,
  output logic [XLEN-1:0]   op2_o,
  output logic [XLEN-1:0]   imm_o,
  output logic [3:0]        alu_op_o,
  output logic [REG_AW-1:0] rd_o,
  output logic              wen_o,
  output logic              legal_o
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            f7_bit5;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic            is_upper;

  assign opcode  = inst_i.r.opcode;
  assign funct3  = inst_i.r.funct3;
  // sub / sra select, same bit position in the r and i views
  assign f7_bit5 = inst_i.r.funct7[5];

  // sign-extended 12-bit immediate
  assign imm_i = {{(XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
  // upper immediate, low 12 bits zero
  assign imm_u = {inst_i.u.imm, 12'b0};

  assign is_upper = (opcode == OP_LUI) || (opcode == OP_AUIPC);
  assign imm_o    = is_upper ? imm_u : imm_i;

  // operand select and alu op per opcode
  always_comb begin
    op1_o    = '0;
    op2_o    = '0;
    alu_op_o = ALU_ADD;
    legal_o  = 1'b1;
    case (opcode)
      OP_LUI: begin
        // 0 + imm
        op2_o = imm_o;
      end
      OP_AUIPC: begin
        op1_o = pc_i;
        op2_o = imm_o;
      end
      OP_IMM: begin
        op1_o = rdata1_i;
        op2_o = imm_o;
        // only srai looks at bit 30, addi with a negative imm must stay add
        if (funct3 == 3'b101) begin
          alu_op_o = {f7_bit5, funct3};
        end else begin
          alu_op_o = {1'b0, funct3};
        end
      end
      OP_REG: begin
        op1_o    = rdata1_i;
        op2_o    = rdata2_i;
        alu_op_o = {f7_bit5, funct3};
      end
      default: begin
        // loads, stores, branches, system... not handled here
        legal_o = 1'b0;
      end
    endcase
  end

  // rv32e, upper index bit is ignored
  assign rd_o  = inst_i.r.rd[REG_AW-1:0];
  // x0 writes are dropped at decode
  assign wen_o = legal_o && (rd_o != '0);

endmodule

// File: hw/decode/idu_stage.sv
`timescale 1ns/10ps

module idu_stage import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // fetch side
  input  logic              inst_valid_i,
  input  logic [XLEN-1:0]   inst_i,
  input  logic [XLEN-1:0]   pc_i,
  output logic              inst_ready_o,
  output logic              illegal_o,
  // register file read and scoreboard
  output logic [REG_AW-1:0] rs1_o,
  output logic [REG_AW-1:0] rs2_o,
  input  logic [XLEN-1:0]   rdata1_i,
  input  logic [XLEN-1:0]   rdata2_i,
  input  logic              busy1_i,
  input  logic              busy2_i,
  output logic              mark_o,
  output logic [REG_AW-1:0] mark_rd_o,
  // micro-op push
  uop_if.prod               uop
);

  inst_u             inst_q;
  logic [XLEN-1:0]   pc_q;
  logic              valid_q;
  logic [CRED_W-1:0] cred_q;

  logic [6:0]        opcode;
  logic              uses_rs1;
  logic              uses_rs2;
  logic              hazard;
  logic              legal;
  logic              push;
  logic              discard;
  logic              take;

  logic [XLEN-1:0]   op1;
  logic [XLEN-1:0]   op2;
  logic [3:0]        alu_op;
  logic [REG_AW-1:0] rd;
  logic              wen;

  assign opcode = inst_q.r.opcode;
  assign rs1_o  = inst_q.r.rs1[REG_AW-1:0];
  assign rs2_o  = inst_q.r.rs2[REG_AW-1:0];

  // lui/auipc read nothing, op-imm only rs1
  assign uses_rs1 = (opcode == OP_IMM) || (opcode == OP_REG);
  assign uses_rs2 = (opcode == OP_REG);
  // busy already accounts for a writeback landing this cycle
  assign hazard   = (uses_rs1 && busy1_i) || (uses_rs2 && busy2_i);

  assign push    = valid_q && legal && !hazard && (cred_q != '0);
  // bad opcode is dropped one cycle after capture
  assign discard = valid_q && !legal;
  assign illegal_o = discard;

  // refill on the same edge the stage drains
  assign inst_ready_o = !valid_q || push || discard;
  assign take         = inst_valid_i && inst_ready_o;

  idu_decoder u_decoder (
    .inst_i   (inst_q),
    .pc_i     (pc_q),
    .rdata1_i (rdata1_i),
    .rdata2_i (rdata2_i),
    .op1_o    (op1),
    .op2_o    (op2),
    // immediate is already folded into op2
    .imm_o    (),
    .alu_op_o (alu_op),
    .rd_o     (rd),
    .wen_o    (wen),
    .legal_o  (legal)
  );

  assign uop.push        = push;
  assign uop.push_alu_op = alu_op;
  assign uop.push_op1    = op1;
  assign uop.push_op2    = op2;
  assign uop.push_rd     = rd;
  assign uop.push_wen    = wen;

  // rd goes pending as the uop leaves decode
  assign mark_o    = push && wen;
  assign mark_rd_o = rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (push || discard) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  // one credit spent per push, one back per buffer pop
  always_ff @(posedge clk) begin
    if (rst) begin
      cred_q <= CRED_W'(FIFO_DEPTH);
    end else if (push && !uop.credit) begin
      cred_q <= cred_q - 1'b1;
    end else if (!push && uop.credit) begin
      cred_q <= cred_q + 1'b1;
    end
  end

  // buffer never returns more than it was given
  cred_max_a: assert property (@(posedge clk) disable iff (rst) cred_q <= CRED_W'(FIFO_DEPTH))
    else $error("credit count %0d above buffer depth", cred_q);

endmodule

// File: hw/regfile/reg_file.sv
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [REG_AW-1:0] rs1_i,
  input  logic [REG_AW-1:0] rs2_i,
  output logic [XLEN-1:0]   rdata1_o,
  output logic [XLEN-1:0]   rdata2_o,
  output logic              busy1_o,
  output logic              busy2_o,
  input  logic              mark_i,
  input  logic [REG_AW-1:0] mark_rd_i,
  input  logic              wb_i,
  input  logic [REG_AW-1:0] wb_rd_i,
  input  logic [XLEN-1:0]   wb_data_i
);

  logic [XLEN-1:0]   regs_q [NREG];
  // writes in flight per register, several may target one rd
  // busy means nonzero, at most FIFO_DEPTH+1 pending
  logic [CRED_W-1:0] pend_q [NREG];
  logic              hit1;
  logic              hit2;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NREG; r++) begin
        regs_q[r] <= '0;
        pend_q[r] <= '0;
      end
    end else begin
      // x0 never written, stays zero
      if (wb_i && (wb_rd_i != '0)) begin
        regs_q[wb_rd_i] <= wb_data_i;
      end
      // mark and writeback on one rd cancel, register stays busy
      for (int r = 1; r < NREG; r++) begin
        if (mark_i && (mark_rd_i == REG_AW'(r)) && !(wb_i && (wb_rd_i == REG_AW'(r)))) begin
          pend_q[r] <= pend_q[r] + 1'b1;
        end else if (wb_i && (wb_rd_i == REG_AW'(r)) && !(mark_i && (mark_rd_i == REG_AW'(r)))) begin
          pend_q[r] <= pend_q[r] - 1'b1;
        end
      end
    end
  end

  // same-cycle writeback bypass
  assign hit1 = wb_i && (wb_rd_i == rs1_i) && (rs1_i != '0);
  assign hit2 = wb_i && (wb_rd_i == rs2_i) && (rs2_i != '0);

  assign rdata1_o = (rs1_i == '0) ? '0 : (hit1 ? wb_data_i : regs_q[rs1_i]);
  assign rdata2_o = (rs2_i == '0) ? '0 : (hit2 ? wb_data_i : regs_q[rs2_i]);

  // the writeback seen now already retires one pending write
  assign busy1_o = (pend_q[rs1_i] - CRED_W'(hit1)) != '0;
  assign busy2_o = (pend_q[rs2_i] - CRED_W'(hit2)) != '0;

  // every accepted writeback was marked by decode earlier
  wb_pending_a: assert property (@(posedge clk) disable iff (rst) wb_i |-> pend_q[wb_rd_i] != '0)
    else $error("writeback to x%0d with nothing pending", wb_rd_i);

endmodule

// File: hw/uop_fifo.sv
`timescale 1ns/10ps

module uop_fifo import rv_pkg::*; (
  input logic     clk,
  input logic     rst,
  uop_if.buf_in   in,
  uop_if.buf_out  out
);

  logic [3:0]        alu_op_q [FIFO_DEPTH];
  logic [XLEN-1:0]   op1_q    [FIFO_DEPTH];
  logic [XLEN-1:0]   op2_q    [FIFO_DEPTH];
  logic [REG_AW-1:0] rd_q     [FIFO_DEPTH];
  logic              wen_q    [FIFO_DEPTH];

  // depth is a power of two, pointers wrap on their own
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
  logic [CRED_W-1:0]             cnt_q;

  always_ff @(posedge clk) begin
    if (in.push) begin
      alu_op_q[wr_ptr_q] <= in.push_alu_op;
      op1_q[wr_ptr_q]    <= in.push_op1;
      op2_q[wr_ptr_q]    <= in.push_op2;
      rd_q[wr_ptr_q]     <= in.push_rd;
      wen_q[wr_ptr_q]    <= in.push_wen;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (in.push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (out.pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (in.push && !out.pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!in.push && out.pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // head entry, visible the cycle after its push
  assign out.pop_valid  = cnt_q != '0;
  assign out.pop_alu_op = alu_op_q[rd_ptr_q];
  assign out.pop_op1    = op1_q[rd_ptr_q];
  assign out.pop_op2    = op2_q[rd_ptr_q];
  assign out.pop_rd     = rd_q[rd_ptr_q];
  assign out.pop_wen    = wen_q[rd_ptr_q];

  // freed slot goes straight back to decode as a credit
  assign in.credit = out.pop;

  // decode credits must keep pushes off a full buffer
  no_overflow_a: assert property (@(posedge clk) disable iff (rst)
    in.push |-> cnt_q != CRED_W'(FIFO_DEPTH))
    else $error("push while buffer full");
  no_underflow_a: assert property (@(posedge clk) disable iff (rst) out.pop |-> cnt_q != '0)
    else $error("pop while buffer empty");

endmodule

// File: hw/alu_exec.sv
`timescale 1ns/10ps

module alu_exec import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  uop_if.cons               uop,
  input  logic              wb_ready_i,
  output logic              wb_valid_o,
  output logic [REG_AW-1:0] wb_rd_o,
  output logic [XLEN-1:0]   wb_data_o,
  output logic              wb_o
);

  logic                     wb_valid_q;
  logic [REG_AW-1:0]        rd_q;
  logic [XLEN-1:0]          data_q;
  logic [XLEN-1:0]          result;
  logic [$clog2(XLEN)-1:0]  shamt;
  logic                     pop;

  // take the next uop once the result slot is free or draining
  assign pop     = uop.pop_valid && (!wb_valid_q || wb_ready_i);
  assign uop.pop = pop;

  // only the low bits of op2 count for shifts
  assign shamt = uop.pop_op2[$clog2(XLEN)-1:0];

  always_comb begin
    case (uop.pop_alu_op)
      ALU_ADD:  result = uop.pop_op1 + uop.pop_op2;
      ALU_SUB:  result = uop.pop_op1 - uop.pop_op2;
      ALU_SLL:  result = uop.pop_op1 << shamt;
      ALU_SLT:  result = XLEN'($signed(uop.pop_op1) < $signed(uop.pop_op2));
      ALU_SLTU: result = XLEN'(uop.pop_op1 < uop.pop_op2);
      ALU_XOR:  result = uop.pop_op1 ^ uop.pop_op2;
      ALU_SRL:  result = uop.pop_op1 >> shamt;
      ALU_SRA:  result = $signed(uop.pop_op1) >>> shamt;
      ALU_OR:   result = uop.pop_op1 | uop.pop_op2;
      ALU_AND:  result = uop.pop_op1 & uop.pop_op2;
      // funct7 combos with no rv32i meaning
      default:  result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_q <= 1'b0;
    end else if (pop) begin
      // rd x0 uops retire here without a writeback
      wb_valid_q <= uop.pop_wen;
    end else if (wb_ready_i) begin
      wb_valid_q <= 1'b0;
    end
  end

  // held stable while the writeback waits
  always_ff @(posedge clk) begin
    if (pop) begin
      rd_q   <= uop.pop_rd;
      data_q <= result;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_rd_o    = rd_q;
  assign wb_data_o  = data_q;
  // accepted writeback, updates the register file
  assign wb_o       = wb_valid_q && wb_ready_i;

endmodule

// File: hw/decode_top.sv
`timescale 1ns/10ps

module decode_top import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              inst_valid_i,
  input  logic [XLEN-1:0]   inst_i,
  input  logic [XLEN-1:0]   pc_i,
  output logic              inst_ready_o,
  input  logic              wb_ready_i,
  output logic              wb_valid_o,
  output logic [REG_AW-1:0] wb_rd_o,
  output logic [XLEN-1:0]   wb_data_o,
  output logic              illegal_o
);

  // decode to register file
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [XLEN-1:0]   rdata1;
  logic [XLEN-1:0]   rdata2;
  logic              busy1;
  logic              busy2;
  logic              mark;
  logic [REG_AW-1:0] mark_rd;
  // accepted writeback strobe
  logic              wb;

  uop_if u_uop ();

  idu_stage u_idu (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .inst_ready_o (inst_ready_o),
    .illegal_o    (illegal_o),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .busy1_i      (busy1),
    .busy2_i      (busy2),
    .mark_o       (mark),
    .mark_rd_o    (mark_rd),
    .uop          (u_uop.prod)
  );

  reg_file u_rf (
    .clk       (clk),
    .rst       (rst),
    .rs1_i     (rs1),
    .rs2_i     (rs2),
    .rdata1_o  (rdata1),
    .rdata2_o  (rdata2),
    .busy1_o   (busy1),
    .busy2_o   (busy2),
    .mark_i    (mark),
    .mark_rd_i (mark_rd),
    .wb_i      (wb),
    .wb_rd_i   (wb_rd_o),
    .wb_data_i (wb_data_o)
  );

  uop_fifo u_fifo (
    .clk (clk),
    .rst (rst),
    .in  (u_uop.buf_in),
    .out (u_uop.buf_out)
  );

  alu_exec u_exec (
    .clk        (clk),
    .rst        (rst),
    .uop        (u_uop.cons),
    .wb_ready_i (wb_ready_i),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o),
    .wb_o       (wb)
  );

endmodule

// File: test/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// architectural register state, updated in program order
logic [XLEN-1:0] model_regs [NREG];

// all zero, same as the dut after reset
function automatic void model_reset();
  for (int r = 0; r < NREG; r++) begin
    model_regs[r] = '0;
  end
endfunction

// runs one instruction on the model
// returns 1 when a writeback to rd is due, bad flags an unknown opcode
function automatic logic ref_exec(input logic [31:0] inst, input logic [31:0] pc,
                                  output logic [REG_AW-1:0] rd,
                                  output logic [XLEN-1:0] val, output logic bad);
  logic [6:0]      opcode;
  logic [2:0]      f3;
  logic            alt;
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [4:0]      sh;
  opcode = inst[6:0];
  f3     = inst[14:12];
  // bit 30 picks sub and sra
  alt    = inst[30];
  rd     = inst[10:7];
  a      = model_regs[inst[18:15]];
  // second operand is rs2 for op, the sign-extended imm otherwise
  if (opcode == OP_REG) begin
    b = model_regs[inst[23:20]];
  end else begin
    b = {{20{inst[31]}}, inst[31:20]};
  end
  sh  = b[4:0];
  bad = 1'b0;
  val = '0;
  case (opcode)
    OP_LUI: val = {inst[31:12], 12'b0};
    OP_AUIPC: val = pc + {inst[31:12], 12'b0};
    OP_IMM, OP_REG: begin
      case (f3)
        3'b000: begin
          if (opcode == OP_REG && alt) begin
            val = a - b;
          end else begin
            val = a + b;
          end
        end
        3'b001: val = a << sh;
        3'b010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: val = (a < b) ? 32'd1 : 32'd0;
        3'b100: val = a ^ b;
        3'b101: begin
          if (alt) begin
            val = $signed(a) >>> sh;
          end else begin
            val = a >> sh;
          end
        end
        3'b110: val = a | b;
        default: val = a & b;
      endcase
    end
    default: bad = 1'b1;
  endcase
  // x0 stays zero
  if (!bad && rd != '0) begin
    model_regs[rd] = val;
  end
  return !bad && (rd != '0);
endfunction

`endif

// File: test/tb_decode_top.sv
`timescale 1ns/10ps

module tb_decode_top import rv_pkg::*; ();

  logic              clk;
  logic              rst;
  logic              inst_valid_i;
  logic [XLEN-1:0]   inst_i;
  logic [XLEN-1:0]   pc_i;
  logic              inst_ready_o;
  logic              wb_ready_i;
  logic              wb_valid_o;
  logic [REG_AW-1:0] wb_rd_o;
  logic [XLEN-1:0]   wb_data_o;
  logic              illegal_o;

  // stimulus stream and a separate stream for the ready stalls
  int seed       = 32'h590b184b;
  int stall_seed = 32'h590b184b;
  // cycles any single wait may take
  int wait_limit = 2000;

  // expected writebacks in program order
  logic [REG_AW-1:0] exp_rd_q   [$];
  logic [XLEN-1:0]   exp_data_q [$];

  string           test_name;
  int              checks;
  int              errors;
  int              test_err_base;
  int              tests_run;
  int              tests_clean;
  int              illegal_seen;
  int              illegal_exp;
  int              bp_mode;
  int              gap_mode;
  // fetch held off while the writeback side is frozen
  int              fetch_blocked;
  logic [XLEN-1:0] pc;

  decode_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .inst_ready_o (inst_ready_o),
    .wb_ready_i   (wb_ready_i),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o),
    .illegal_o    (illegal_o)
  );

  `include "tb_ref.svh"

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // instruction encoders
  function automatic logic [31:0] make_r(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
  endfunction

  function automatic logic [31:0] make_i(input logic [11:0] imm, input int rs1,
                                         input logic [2:0] f3, input int rd);
    return {imm, 5'(rs1), f3, 5'(rd), OP_IMM};
  endfunction

  function automatic logic [31:0] make_u(input logic [6:0] op, input logic [19:0] imm,
                                         input int rd);
    return {imm, 5'(rd), op};
  endfunction

  // random legal alu instruction on x0..x15
  function automatic logic [31:0] rand_inst();
    logic [31:0] r;
    logic [31:0] f;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    r  = $random(seed);
    f  = $random(seed);
    f3 = f[2:0];
    case (r[2:0])
      3'd0: return make_u(OP_LUI, f[31:12], r[6:3]);
      3'd1: return make_u(OP_AUIPC, f[31:12], r[6:3]);
      3'd2, 3'd3, 3'd4: begin
        imm = f[31:20];
        // shifts need a clean upper field
        if (f3 == 3'b001) begin
          imm = {7'b0, f[24:20]};
        end else if (f3 == 3'b101) begin
          imm = {1'b0, f[30], 5'b0, f[24:20]};
        end
        return make_i(imm, r[10:7], f3, r[6:3]);
      end
      default: begin
        // only add and srl have a funct7 variant
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && f[30]) ? 7'b0100000 : 7'b0;
        return make_r(f7, r[14:11], r[10:7], f3, r[6:3]);
      end
    endcase
  endfunction

  task automatic fail_timeout(input string what);
    $display("timeout waiting for %s in test %s", what, test_name);
    $display("TEST FAILED");
    $finish;
  endtask

  // offer one instruction, wait for the fetch handshake, then update the model
  task automatic send_inst(input logic [XLEN-1:0] inst);
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   val;
    logic              bad;
    logic              wb_due;
    logic              done;
    logic [31:0]       r;
    int                n;
    done = 1'b0;
    n = 0;
    inst_valid_i = 1'b1;
    inst_i = inst;
    pc_i = pc;
    while (!done) begin
      // ready is settled by mid-cycle
      @(negedge clk);
      done = inst_ready_o;
      @(posedge clk);
      #1;
      n++;
      if (!done && n > wait_limit) begin
        fail_timeout("fetch handshake");
      end
    end
    wb_due = ref_exec(inst, pc, rd, val, bad);
    if (wb_due) begin
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(val);
    end
    if (bad) begin
      illegal_exp++;
    end
    pc = pc + 4;
    inst_valid_i = 1'b0;
    // optional idle cycle on the fetch side
    r = $random(seed);
    if (gap_mode != 0 && r[1:0] == 2'b00) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err_base = errors;
  endtask

  // wait for the last writeback, then close the test
  task automatic end_test();
    int n;
    int errs;
    n = 0;
    while (exp_rd_q.size() != 0) begin
      @(posedge clk);
      #1;
      n++;
      if (n > wait_limit) begin
        fail_timeout("outstanding writebacks");
      end
    end
    checks++;
    if (illegal_seen != illegal_exp) begin
      errors++;
      $display("ERROR %s illegal count expected %0d actual %0d", test_name, illegal_exp,
               illegal_seen);
    end
    errs = errors - test_err_base;
    tests_run++;
    if (errs == 0) begin
      tests_clean++;
    end
    $display("test %-12s done, %0d errors", test_name, errs);
  endtask

  // writeback ready, random with long dry spells when back-pressure is on
  initial begin
    int          stretch;
    logic [31:0] r;
    stretch = 0;
    forever begin
      @(posedge clk);
      #1;
      r = $random(stall_seed);
      if (bp_mode == 0) begin
        wb_ready_i = 1'b1;
      end else if (stretch > 0) begin
        wb_ready_i = 1'b0;
        stretch--;
      end else if (r[4:0] == 5'd0) begin
        // long enough to use up every credit
        stretch = 10 + r[9:6];
        wb_ready_i = 1'b0;
      end else begin
        wb_ready_i = r[5];
      end
    end
  end

  // compare each accepted writeback against the head of the expected queue
  initial begin
    logic [REG_AW-1:0] e_rd;
    logic [XLEN-1:0]   e_data;
    forever begin
      @(negedge clk);
      if (!rst && illegal_o) begin
        illegal_seen++;
      end
      if (!rst && inst_valid_i && !inst_ready_o && wb_valid_o && !wb_ready_i) begin
        fetch_blocked++;
      end
      if (!rst && wb_valid_o && wb_ready_i) begin
        if (exp_rd_q.size() == 0) begin
          errors++;
          $display("writeback to x%0d in test %s arrived with nothing pending", wb_rd_o,
                   test_name);
        end else begin
          e_rd = exp_rd_q.pop_front();
          e_data = exp_data_q.pop_front();
          checks += 2;
          if (wb_rd_o !== e_rd) begin
            errors++;
            $display("ERROR %s rd expected x%0d actual x%0d", test_name, e_rd, wb_rd_o);
          end
          if (wb_data_o !== e_data) begin
            errors++;
            $display("ERROR %s data expected %h actual %h", test_name, e_data, wb_data_o);
          end
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    inst_valid_i = 1'b0;
    inst_i = '0;
    pc_i = '0;
    wb_ready_i = 1'b1;
    bp_mode = 0;
    gap_mode = 0;
    pc = 32'h0000_1000;
    checks = 0;
    errors = 0;
    tests_run = 0;
    tests_clean = 0;
    illegal_seen = 0;
    illegal_exp = 0;
    fetch_blocked = 0;
    model_reset();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    start_test("reset");
    checks += 3;
    if (inst_ready_o !== 1'b1) begin
      errors++;
      $display("ERROR reset inst_ready_o expected 1 actual %b", inst_ready_o);
    end
    if (wb_valid_o !== 1'b0) begin
      errors++;
      $display("ERROR reset wb_valid_o expected 0 actual %b", wb_valid_o);
    end
    if (illegal_o !== 1'b0) begin
      errors++;
      $display("ERROR reset illegal_o expected 0 actual %b", illegal_o);
    end
    end_test();

    start_test("op_alu");
    // x1 = -5, x2 = 0x80000123, x3 = 2047
    send_inst(make_i(12'hffb, 0, 3'b000, 1));
    send_inst(make_u(OP_LUI, 20'h80000, 2));
    send_inst(make_i(12'h123, 2, 3'b110, 2));
    send_inst(make_i(12'h7ff, 0, 3'b000, 3));
    send_inst(make_r(7'h00, 3, 1, 3'b000, 4));
    send_inst(make_r(7'h20, 3, 1, 3'b000, 5));
    send_inst(make_i(12'h004, 1, 3'b001, 6));
    // srai and sra on a negative value
    send_inst(make_i(12'h407, 2, 3'b101, 7));
    send_inst(make_i(12'h007, 2, 3'b101, 8));
    send_inst(make_r(7'h20, 3, 2, 3'b101, 9));
    send_inst(make_r(7'h00, 3, 1, 3'b001, 10));
    send_inst(make_r(7'h00, 3, 1, 3'b010, 11));
    send_inst(make_r(7'h00, 3, 1, 3'b011, 12));
    send_inst(make_i(12'hfff, 1, 3'b010, 13));
    send_inst(make_i(12'hfff, 1, 3'b011, 14));
    send_inst(make_r(7'h00, 2, 1, 3'b100, 15));
    send_inst(make_r(7'h00, 2, 1, 3'b110, 4));
    send_inst(make_r(7'h00, 2, 1, 3'b111, 5));
    send_inst(make_i(12'h8f0, 1, 3'b100, 6));
    send_inst(make_i(12'h0f0, 1, 3'b111, 7));
    send_inst(make_r(7'h00, 3, 2, 3'b101, 8));
    repeat (20) send_inst(rand_inst());
    end_test();

    start_test("upper_imm");
    send_inst(make_u(OP_LUI, 20'habcde, 4));
    send_inst(make_u(OP_LUI, 20'hfffff, 5));
    send_inst(make_u(OP_AUIPC, 20'h12345, 6));
    // pc minus 4 KiB
    send_inst(make_u(OP_AUIPC, 20'hfffff, 7));
    end_test();

    start_test("dep_chain");
    send_inst(make_i(12'h001, 0, 3'b000, 1));
    repeat (6) begin
      send_inst(make_r(7'h00, 1, 1, 3'b000, 1));
      send_inst(make_i(12'hfff, 1, 3'b000, 2));
      send_inst(make_r(7'h20, 1, 2, 3'b000, 3));
      send_inst(make_r(7'h00, 2, 3, 3'b110, 1));
    end
    // same rd several times in flight
    repeat (5) send_inst(make_i(12'h003, 1, 3'b000, 1));
    send_inst(make_r(7'h00, 1, 1, 3'b000, 4));
    end_test();

    start_test("backpressure");
    bp_mode = 1;
    gap_mode = 1;
    fetch_blocked = 0;
    repeat (80) send_inst(rand_inst());
    // a frozen writeback side has to reach back to fetch
    checks++;
    if (fetch_blocked == 0) begin
      errors++;
      $display("fetch was never held off while writebacks were stalled in test %s",
               test_name);
    end
    end_test();
    bp_mode = 0;
    gap_mode = 0;

    start_test("illegal");
    send_inst(make_i(12'h055, 0, 3'b000, 9));
    // load, store, branch, jal, csr, all naming x9
    send_inst({12'h004, 5'd9, 3'b010, 5'd9, 7'b0000011});
    send_inst({7'h00, 5'd9, 5'd9, 3'b010, 5'd4, 7'b0100011});
    send_inst({7'h00, 5'd9, 5'd0, 3'b000, 5'd8, 7'b1100011});
    send_inst({20'h00010, 5'd9, 7'b1101111});
    send_inst({12'h000, 5'd0, 3'b001, 5'd9, 7'b1110011});
    // x9 must still hold 0x55
    send_inst(make_i(12'h000, 9, 3'b000, 10));
    end_test();

    start_test("x0");
    send_inst(make_i(12'h07b, 1, 3'b000, 0));
    send_inst(make_r(7'h00, 2, 1, 3'b000, 0));
    send_inst(make_u(OP_LUI, 20'h12345, 0));
    send_inst(make_r(7'h00, 0, 0, 3'b110, 11));
    send_inst(make_i(12'h001, 0, 3'b000, 12));
    send_inst(make_r(7'h00, 0, 3, 3'b000, 13));
    end_test();

    $display("tests %0d run, %0d clean, %0d checks, %0d errors", tests_run, tests_clean,
             checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+test
common/rv_pkg.sv
common/uop_if.sv
hw/decode/idu_decoder.sv
hw/decode/idu_stage.sv
hw/regfile/reg_file.sv
hw/uop_fifo.sv
hw/alu_exec.sv
hw/decode_top.sv
test/tb_decode_top.sv

// File: Bender.yml
package:
  name: decode_top

sources:
  - files:
      - common/rv_pkg.sv
      - common/uop_if.sv
      - hw/decode/idu_decoder.sv
      - hw/decode/idu_stage.sv
      - hw/regfile/reg_file.sv
      - hw/uop_fifo.sv
      - hw/alu_exec.sv
      - hw/decode_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_decode_top.sv
